//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_cpu
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
RUN_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- common/lc3b_isa_pkg.sv
package lc3b_isa_pkg;

	localparam int OPCODE_W = 4;

	// only the implemented subset, anything else decodes as a nop
	typedef enum logic [OPCODE_W-1:0] {
		op_br  = 4'd0,
		op_add = 4'd1,
		op_stb = 4'd3,
		op_and = 4'd5,
		op_ldr = 4'd6,
		op_str = 4'd7,
		op_not = 4'd9
	} lc3b_opcode;

	typedef enum logic [1:0] {alu_add, alu_and, alu_not, alu_pass} alu_op_t;

	typedef enum logic {wb_alu, wb_mem} wb_sel_t;

	localparam lc3b_types::lc3b_word NOP_INSTR = 16'h0000; // br with nzp 000
	localparam lc3b_types::lc3b_word RESET_PC = 16'h0000;

endpackage : lc3b_isa_pkg

//--- common/lc3b_types.sv
package lc3b_types;

	localparam int WORD_W = 16;
	localparam int REG_W = 3;
	localparam int NUM_REGS = 1 << REG_W;
	localparam int MASK_W = 2;
	localparam int NZP_W = 3;

	// data, address and instruction words share one width
	typedef logic [WORD_W-1:0] lc3b_word;

	typedef logic [REG_W-1:0] lc3b_reg;

	typedef logic [MASK_W-1:0] lc3b_mem_wmask; // bit 1 is the high byte

	typedef logic [NZP_W-1:0] lc3b_nzp; // n, z, p

endpackage : lc3b_types

//--- decode/instruction_decode.sv
`timescale 1ns/1ns

module instruction_decode (
	input logic clk,
	input logic reset,
	input logic flow,
	input logic bubble,
	input logic squash,
	input lc3b_types::lc3b_word if_ir,
	input lc3b_types::lc3b_word if_pc,
	input logic wb_load,
	input lc3b_types::lc3b_reg wb_dest,
	input lc3b_types::lc3b_word wb_data,
	output lc3b_types::lc3b_word id_sr1_val,
	output lc3b_types::lc3b_word id_sr2_val,
	output lc3b_types::lc3b_reg id_sr1,
	output lc3b_types::lc3b_reg id_sr2,
	output lc3b_types::lc3b_reg id_dest,
	output lc3b_types::lc3b_word id_imm,
	output lc3b_isa_pkg::alu_op_t id_alu_op,
	output logic id_use_imm,
	output lc3b_isa_pkg::wb_sel_t id_wb_sel,
	output logic id_reg_load,
	output logic id_mem_read,
	output logic id_mem_write,
	output logic id_byte_store,
	output logic id_branch,
	output lc3b_types::lc3b_nzp id_nzp,
	output lc3b_types::lc3b_reg dec_sr1,
	output lc3b_types::lc3b_reg dec_sr2,
	output logic dec_uses_sr1,
	output logic dec_uses_sr2
);
	import lc3b_types::*;
	import lc3b_isa_pkg::*;

	lc3b_word rf [NUM_REGS];
	lc3b_word sr1_val, sr2_val, imm;
	lc3b_opcode opcode;
	alu_op_t alu_op;
	wb_sel_t wb_sel;
	logic use_imm, reg_load, mem_read, mem_write, byte_store, branch;
	logic is_store;

	assign opcode = lc3b_opcode'(if_ir[15:12]);
	assign is_store = (opcode == op_str) || (opcode == op_stb);
	assign dec_sr1 = if_ir[8:6];
	assign dec_sr2 = is_store ? if_ir[11:9] : if_ir[2:0]; // stores read the source field

	always_comb begin
		alu_op = alu_add;
		wb_sel = wb_alu;
		use_imm = 1'b1;
		reg_load = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		byte_store = 1'b0;
		branch = 1'b0;
		dec_uses_sr1 = 1'b0;
		dec_uses_sr2 = 1'b0;
		imm = {{9{if_ir[5]}}, if_ir[5:0], 1'b0}; // word offset
		case (opcode)
			op_add, op_and: begin
				alu_op = (opcode == op_add) ? alu_add : alu_and;
				use_imm = if_ir[5];
				reg_load = 1'b1;
				dec_uses_sr1 = 1'b1;
				dec_uses_sr2 = ~if_ir[5];
				imm = {{11{if_ir[4]}}, if_ir[4:0]};
			end
			op_not: begin
				alu_op = alu_not;
				reg_load = 1'b1;
				dec_uses_sr1 = 1'b1;
			end
			op_ldr: begin
				wb_sel = wb_mem;
				reg_load = 1'b1;
				mem_read = 1'b1;
				dec_uses_sr1 = 1'b1;
			end
			op_str, op_stb: begin
				mem_write = 1'b1;
				dec_uses_sr1 = 1'b1;
				dec_uses_sr2 = 1'b1;
				if (opcode == op_stb) begin
					byte_store = 1'b1;
					imm = {{10{if_ir[5]}}, if_ir[5:0]}; // byte offset
				end
			end
			op_br: begin
				alu_op = alu_pass;
				branch = |if_ir[11:9]; // nzp 000 never branches
				imm = if_pc + {{6{if_ir[8]}}, if_ir[8:0], 1'b0};
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (wb_load)
			rf[wb_dest] <= wb_data;
	end

	// same-cycle write shows up on the read side
	assign sr1_val = (wb_load && wb_dest == dec_sr1) ? wb_data : rf[dec_sr1];
	assign sr2_val = (wb_load && wb_dest == dec_sr2) ? wb_data : rf[dec_sr2];

	always_ff @(posedge clk) begin
		if (reset) begin
			id_reg_load <= 1'b0;
			id_mem_read <= 1'b0;
			id_mem_write <= 1'b0;
			id_byte_store <= 1'b0;
			id_branch <= 1'b0;
		end else if (flow) begin
			id_reg_load <= reg_load & ~(squash | bubble);
			id_mem_read <= mem_read & ~(squash | bubble);
			id_mem_write <= mem_write & ~(squash | bubble);
			id_byte_store <= byte_store & ~(squash | bubble);
			id_branch <= branch & ~(squash | bubble);
		end
	end

	always_ff @(posedge clk) begin
		if (flow) begin
			id_sr1_val <= sr1_val;
			id_sr2_val <= sr2_val;
			id_sr1 <= dec_sr1;
			id_sr2 <= dec_sr2;
			id_dest <= if_ir[11:9];
			id_imm <= imm;
			id_alu_op <= alu_op;
			id_use_imm <= use_imm;
			id_wb_sel <= wb_sel;
			id_nzp <= if_ir[11:9];
		end
	end

endmodule : instruction_decode

//--- dv/cpu_assert.sv
`timescale 1ns/1ns

module cpu_assert (
	input logic clk,
	input logic reset,
	input logic flow,
	input logic squash,
	input lc3b_types::lc3b_word mem_addr1,
	input logic mem_read1,
	input logic resp_a,
	input lc3b_types::lc3b_word mem_addr2,
	input logic mem_read2,
	input logic mem_write2,
	input lc3b_types::lc3b_word mem_wdata2,
	input logic resp_b
);

	int fail_count = 0;

	fetch_held: assert property (@(posedge clk) disable iff (reset)
		(mem_read1 && !resp_a) |=> (mem_read1 && $stable(mem_addr1)))
		else begin
			$error("fetch request changed before resp_a");
			fail_count++;
		end

	read_held: assert property (@(posedge clk) disable iff (reset)
		(mem_read2 && !resp_b) |=> (mem_read2 && $stable(mem_addr2)))
		else begin
			$error("data read changed before resp_b");
			fail_count++;
		end

	write_held: assert property (@(posedge clk) disable iff (reset)
		(mem_write2 && !resp_b) |=> (mem_write2 && $stable(mem_addr2) && $stable(mem_wdata2)))
		else begin
			$error("data write changed before resp_b");
			fail_count++;
		end

	// one advancing cycle of squash clears the branch
	squash_once: assert property (@(posedge clk) disable iff (reset)
		(squash && flow) |=> !squash)
		else begin
			$error("squash held over two advancing cycles");
			fail_count++;
		end

	rw_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(mem_read2 && mem_write2))
		else begin
			$error("read and write requested together");
			fail_count++;
		end

endmodule : cpu_assert

bind cpu_datapath cpu_assert u_assert (.*);

//--- dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 10
) (
	input logic reset_req,
	output logic clk,
	output logic reset
);

	int left = RESET_CYCLES; // reset is held from time zero

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		if (reset_req)
			left <= RESET_CYCLES;
		else if (left != 0)
			left <= left - 1;
	end

	assign reset = (left != 0);

endmodule : tb_clock

//--- dv/tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu;
	import lc3b_types::*;
	import lc3b_isa_pkg::*;

	localparam int DRIVE_DELAY = 10;
	localparam lc3b_word MARKER_ADDR = 16'h003E; // word offset 31 from r0
	localparam int TIMEOUT_CYCLES = 4000; // six short programs, worst delay 4 per port
	localparam int unsigned SEED = 32'h8938f5ab;

	logic clk, reset, reset_req;
	lc3b_word mem_addr1, mem_rdata1, mem_addr2, mem_wdata2, mem_rdata2;
	logic mem_read1, resp_a, mem_read2, mem_write2, resp_b;
	lc3b_mem_wmask mem_byte_enable2;

	lc3b_word imem [256];
	lc3b_word dmem [256];
	lc3b_word prog [$];
	lc3b_word got_addr [$], got_data [$], exp_addr [$], exp_data [$];
	lc3b_mem_wmask got_mask [$], exp_mask [$];
	int fetch_cnt, fetch_delay, data_cnt, data_delay;
	int cycles;
	bit random_delay, marker_seen;

	tb_clock u_clk (.reset_req, .clk, .reset);

	cpu_datapath u_dut (
		.clk, .reset, .mem_addr1, .mem_read1, .mem_rdata1, .resp_a,
		.mem_addr2, .mem_read2, .mem_write2, .mem_wdata2, .mem_byte_enable2,
		.mem_rdata2, .resp_b
	);

	function automatic lc3b_word add_rr(int dr, int sr1, int sr2);
		return {4'b0001, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
	endfunction

	function automatic lc3b_word add_ri(int dr, int sr1, int imm);
		return {4'b0001, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
	endfunction

	function automatic lc3b_word and_rr(int dr, int sr1, int sr2);
		return {4'b0101, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
	endfunction

	function automatic lc3b_word and_ri(int dr, int sr1, int imm);
		return {4'b0101, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
	endfunction

	function automatic lc3b_word not_rr(int dr, int sr);
		return {4'b1001, 3'(dr), 3'(sr), 6'b111111};
	endfunction

	function automatic lc3b_word load_word(int dr, int base, int off);
		return {4'b0110, 3'(dr), 3'(base), 6'(off)};
	endfunction

	function automatic lc3b_word store_word(int sr, int base, int off);
		return {4'b0111, 3'(sr), 3'(base), 6'(off)};
	endfunction

	function automatic lc3b_word store_byte(int sr, int base, int off);
		return {4'b0011, 3'(sr), 3'(base), 6'(off)};
	endfunction

	function automatic lc3b_word branch(int nzp, int off);
		return {4'b0000, 3'(nzp), 9'(off)};
	endfunction

	function automatic lc3b_word sext5(int v);
		logic [4:0] f;
		f = 5'(v);
		return {{11{f[4]}}, f};
	endfunction

	function automatic lc3b_word lane_bits(lc3b_mem_wmask m);
		return {{8{m[1]}}, {8{m[0]}}};
	endfunction

	function automatic int draw_delay();
		if (random_delay)
			return 1 + int'($urandom % 4);
		return 1;
	endfunction

	task automatic stop_run(string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(string name, lc3b_word exp, lc3b_word act);
		if (exp !== act) begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			$display("=== FAIL ===");
			$fatal(1, "simulation stopped");
		end
	endtask

	task automatic check_mask(string name, lc3b_mem_wmask exp, lc3b_mem_wmask act);
		if (exp !== act) begin
			$display("ERR %s: expected %b, actual %b", name, exp, act);
			$display("=== FAIL ===");
			$fatal(1, "simulation stopped");
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (exp !== act) begin
			$display("ERR %s: expected %b, actual %b", name, exp, act);
			$display("=== FAIL ===");
			$fatal(1, "simulation stopped");
		end
	endtask

	// fetch port model, one word per resp
	task automatic serve_fetch();
		resp_a = 1'b0;
		if (reset || !mem_read1) begin
			fetch_cnt = 0;
		end else begin
			fetch_cnt++;
			if (fetch_cnt >= fetch_delay) begin
				resp_a = 1'b1;
				mem_rdata1 = imem[mem_addr1[8:1]];
				fetch_cnt = 0;
				fetch_delay = draw_delay();
			end
		end
	endtask

	task automatic serve_data();
		lc3b_word idx;
		resp_b = 1'b0;
		idx = {8'h00, mem_addr2[8:1]};
		if (reset || !(mem_read2 || mem_write2)) begin
			data_cnt = 0;
		end else begin
			data_cnt++;
			if (data_cnt >= data_delay) begin
				resp_b = 1'b1;
				mem_rdata2 = dmem[idx];
				if (mem_write2) begin
					if (mem_byte_enable2[0])
						dmem[idx][7:0] = mem_wdata2[7:0];
					if (mem_byte_enable2[1])
						dmem[idx][15:8] = mem_wdata2[15:8];
					got_addr.push_back(mem_addr2);
					got_data.push_back(mem_wdata2);
					got_mask.push_back(mem_byte_enable2);
					if (mem_addr2 == MARKER_ADDR)
						marker_seen = 1'b1;
				end
				data_cnt = 0;
				data_delay = draw_delay();
			end
		end
	endtask

	always @(posedge clk) begin
		#DRIVE_DELAY;
		serve_fetch();
		serve_data();
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: no end of test after %0d cycles", cycles);
			$display("=== FAIL ===");
			$fatal(1, "simulation stopped");
		end
	end

	always @(posedge clk) begin
		#DRIVE_DELAY;
		if (u_dut.u_assert.fail_count != 0)
			stop_run($sformatf("%0d bound assertion failures on handshake or squash",
				u_dut.u_assert.fail_count));
	end

	// reset the core with the program in prog loaded
	task automatic restart();
		@(posedge clk);
		#DRIVE_DELAY;
		reset_req = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		reset_req = 1'b0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = branch(0, i); // never taken, offset follows the address
			dmem[i] = {i[7:0], ~i[7:0]};
		end
		foreach (prog[i])
			imem[i] = prog[i];
		fetch_delay = draw_delay();
		data_delay = draw_delay();
		while (reset) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		got_addr = {};
		got_data = {};
		got_mask = {};
		marker_seen = 1'b0;
	endtask

	task automatic expect_write(lc3b_word addr, lc3b_word data, lc3b_mem_wmask mask);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_mask.push_back(mask);
	endtask

	task automatic run_and_compare(string name);
		while (!marker_seen) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		if (got_addr.size() != exp_addr.size())
			stop_run($sformatf("%s: saw %0d data writes, expected %0d",
				name, got_addr.size(), exp_addr.size()));
		foreach (exp_addr[i]) begin
			check_word($sformatf("%s write %0d addr", name, i), exp_addr[i], got_addr[i]);
			check_mask($sformatf("%s write %0d mask", name, i), exp_mask[i], got_mask[i]);
			check_word($sformatf("%s write %0d data", name, i),
				exp_data[i] & lane_bits(exp_mask[i]), got_data[i] & lane_bits(exp_mask[i]));
		end
		exp_addr = {};
		exp_data = {};
		exp_mask = {};
	endtask

	task automatic test_reset();
		prog = {};
		restart();
		while (!mem_read1) begin
			check_bit("test_reset mem_read2", 1'b0, mem_read2);
			check_bit("test_reset mem_write2", 1'b0, mem_write2);
			@(posedge clk);
			#DRIVE_DELAY;
		end
		check_word("test_reset first fetch", RESET_PC, mem_addr1);
		check_bit("test_reset mem_read2", 1'b0, mem_read2);
		check_bit("test_reset mem_write2", 1'b0, mem_write2);
	endtask

	task automatic run_alu(string name);
		lc3b_word c1, c2, r3, r4, r5, r6, r7;
		c1 = 16'h1234;
		c2 = 16'h0123;
		prog = {and_ri(0, 0, 0), load_word(1, 0, 0), load_word(2, 0, 1),
			add_rr(3, 1, 2), add_ri(4, 3, -3), and_rr(5, 4, 1), and_ri(6, 5, 13),
			not_rr(7, 6), store_word(7, 0, 12), store_word(3, 0, 8),
			store_word(4, 0, 9), store_word(5, 0, 10), store_word(6, 0, 11),
			store_word(7, 0, 31)};
		restart();
		dmem[0] = c1;
		dmem[1] = c2;
		r3 = c1 + c2;
		r4 = r3 + sext5(-3);
		r5 = r4 & c1;
		r6 = r5 & sext5(13);
		r7 = ~r6;
		expect_write(16'd24, r7, 2'b11);
		expect_write(16'd16, r3, 2'b11);
		expect_write(16'd18, r4, 2'b11);
		expect_write(16'd20, r5, 2'b11);
		expect_write(16'd22, r6, 2'b11);
		expect_write(MARKER_ADDR, r7, 2'b11);
		run_and_compare(name);
	endtask

	task automatic test_load_use();
		prog = {and_ri(0, 0, 0), load_word(1, 0, 2), add_rr(2, 1, 1),
			load_word(3, 0, 3), add_rr(4, 0, 3), store_word(2, 0, 13),
			store_word(4, 0, 14), store_word(4, 0, 31)};
		restart();
		dmem[2] = 16'h0041;
		dmem[3] = 16'h7001;
		expect_write(16'd26, 16'h0082, 2'b11);
		expect_write(16'd28, 16'h7001, 2'b11);
		expect_write(MARKER_ADDR, 16'h7001, 2'b11);
		run_and_compare("test_load_use");
	endtask

	task automatic test_byte_store();
		prog = {and_ri(0, 0, 0), load_word(1, 0, 4), add_ri(2, 0, 7),
			store_byte(1, 0, 20), store_byte(1, 2, 0), store_byte(1, 0, 21),
			store_word(1, 0, 31)};
		restart();
		dmem[4] = 16'hBEEF;
		expect_write(16'd20, 16'h00EF, 2'b01);
		expect_write(16'd7, 16'hEF00, 2'b10);
		expect_write(16'd21, 16'hEF00, 2'b10);
		expect_write(MARKER_ADDR, 16'hBEEF, 2'b11);
		run_and_compare("test_byte_store");
	endtask

	task automatic test_branch();
		// stores to offsets 17 and 18 sit in squashed slots
		prog = {and_ri(0, 0, 0), add_ri(1, 0, 5), branch(3'b110, 1),
			store_word(1, 0, 16), branch(3'b001, 2), store_word(1, 0, 17),
			store_word(1, 0, 18), add_ri(2, 0, -2), branch(3'b011, 1),
			store_word(2, 0, 19), branch(3'b100, 2), store_word(1, 0, 17),
			store_word(1, 0, 18), and_ri(3, 0, 0), branch(3'b101, 1),
			store_word(2, 0, 20), branch(3'b010, 3), store_word(1, 0, 17),
			store_word(1, 0, 18), store_word(1, 0, 17), store_word(3, 0, 21),
			branch(3'b111, 1), store_word(1, 0, 18), store_word(1, 0, 22),
			store_word(1, 0, 31)};
		restart();
		expect_write(16'd32, 16'd5, 2'b11);
		expect_write(16'd38, sext5(-2), 2'b11);
		expect_write(16'd40, sext5(-2), 2'b11);
		expect_write(16'd42, 16'd0, 2'b11);
		expect_write(16'd44, 16'd5, 2'b11);
		expect_write(MARKER_ADDR, 16'd5, 2'b11);
		run_and_compare("test_branch");
	endtask

	initial begin
		reset_req = 1'b0;
		resp_a = 1'b0;
		resp_b = 1'b0;
		mem_rdata1 = '0;
		mem_rdata2 = '0;
		random_delay = 1'b0;
		marker_seen = 1'b0;
		cycles = 0;
		fetch_cnt = 0;
		data_cnt = 0;
		void'($urandom(SEED));
		fetch_delay = draw_delay();
		data_delay = draw_delay();
		test_reset();
		run_alu("test_alu");
		test_load_use();
		test_byte_store();
		test_branch();
		random_delay = 1'b1;
		run_alu("test_backpressure");
		random_delay = 1'b0;
		if (u_dut.u_assert.fail_count != 0) begin
			$display("%0d assertion failures", u_dut.u_assert.fail_count);
			$display("=== FAIL ===");
			$fatal(1, "simulation stopped");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule : tb_cpu

//--- execute/execution_module.sv
`timescale 1ns/1ns

module execution_module (
	input logic clk,
	input logic reset,
	input logic flow,
	input logic squash,
	input lc3b_types::lc3b_word id_sr1_val,
	input lc3b_types::lc3b_word id_sr2_val,
	input lc3b_types::lc3b_reg id_sr1,
	input lc3b_types::lc3b_reg id_sr2,
	input lc3b_types::lc3b_reg id_dest,
	input lc3b_types::lc3b_word id_imm,
	input lc3b_isa_pkg::alu_op_t id_alu_op,
	input logic id_use_imm,
	input lc3b_isa_pkg::wb_sel_t id_wb_sel,
	input logic id_reg_load,
	input logic id_mem_read,
	input logic id_mem_write,
	input logic id_byte_store,
	input logic id_branch,
	input lc3b_types::lc3b_nzp id_nzp,
	input lc3b_types::lc3b_reg mem_dest,
	input logic mem_reg_load,
	input lc3b_types::lc3b_word mem_result,
	input lc3b_types::lc3b_reg wb_dest,
	input logic wb_load,
	input lc3b_types::lc3b_word wb_data,
	output lc3b_types::lc3b_word ex_result,
	output lc3b_types::lc3b_word ex_store_data,
	output lc3b_types::lc3b_reg ex_dest,
	output lc3b_isa_pkg::wb_sel_t ex_wb_sel,
	output logic ex_reg_load,
	output logic ex_mem_read,
	output logic ex_mem_write,
	output logic ex_byte_store,
	output logic ex_branch,
	output lc3b_types::lc3b_nzp ex_nzp,
	output lc3b_types::lc3b_word ex_target,
	output lc3b_types::lc3b_reg ex_load_dest,
	output logic ex_is_load
);
	import lc3b_types::*;
	import lc3b_isa_pkg::*;

	lc3b_word op_a, fwd_sr2, op_b, alu_out, store_data;

	// newest producer wins
	function automatic lc3b_word forward(input lc3b_reg src, input lc3b_word reg_val);
		if (mem_reg_load && mem_dest == src)
			return mem_result;
		if (wb_load && wb_dest == src)
			return wb_data;
		return reg_val;
	endfunction

	always_comb begin
		op_a = forward(id_sr1, id_sr1_val);
		fwd_sr2 = forward(id_sr2, id_sr2_val);
	end

	assign op_b = id_use_imm ? id_imm : fwd_sr2;

	always_comb begin
		case (id_alu_op)
			alu_add: alu_out = op_a + op_b; // also base + offset
			alu_and: alu_out = op_a & op_b;
			alu_not: alu_out = ~op_a;
			default: alu_out = op_b;
		endcase
	end

	assign store_data = id_byte_store ? {fwd_sr2[7:0], fwd_sr2[7:0]} : fwd_sr2;
	assign ex_is_load = id_mem_read;
	assign ex_load_dest = id_dest;

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_reg_load <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_byte_store <= 1'b0;
			ex_branch <= 1'b0;
		end else if (flow) begin
			ex_reg_load <= id_reg_load & ~squash;
			ex_mem_read <= id_mem_read & ~squash;
			ex_mem_write <= id_mem_write & ~squash;
			ex_byte_store <= id_byte_store & ~squash;
			ex_branch <= id_branch & ~squash;
		end
	end

	always_ff @(posedge clk) begin
		if (flow) begin
			ex_result <= alu_out;
			ex_store_data <= store_data;
			ex_dest <= id_dest;
			ex_wb_sel <= id_wb_sel;
			ex_nzp <= id_nzp;
			ex_target <= id_imm;
		end
	end

endmodule : execution_module

//--- sim.f
common/lc3b_types.sv
common/lc3b_isa_pkg.sv
source/flow_control.sv
source/instruction_fetch.sv
decode/instruction_decode.sv
execute/execution_module.sv
source/memory_module.sv
source/writeback_module.sv
source/cpu_datapath.sv
dv/tb_clock.sv
dv/cpu_assert.sv
dv/tb_cpu.sv

//--- source/cpu_datapath.sv
`timescale 1ns/1ns

module cpu_datapath (
	input logic clk,
	input logic reset,
	output lc3b_types::lc3b_word mem_addr1,
	output logic mem_read1,
	input lc3b_types::lc3b_word mem_rdata1,
	input logic resp_a,
	output lc3b_types::lc3b_word mem_addr2,
	output logic mem_read2,
	output logic mem_write2,
	output lc3b_types::lc3b_word mem_wdata2,
	output lc3b_types::lc3b_mem_wmask mem_byte_enable2,
	input lc3b_types::lc3b_word mem_rdata2,
	input logic resp_b
);
	import lc3b_types::*;
	import lc3b_isa_pkg::*;

	logic flow, bubble, squash;
	lc3b_word br_target, if_ir, if_pc;

	lc3b_word id_sr1_val, id_sr2_val, id_imm;
	lc3b_reg id_sr1, id_sr2, id_dest, dec_sr1, dec_sr2;
	alu_op_t id_alu_op;
	wb_sel_t id_wb_sel;
	lc3b_nzp id_nzp;
	logic id_use_imm, id_reg_load, id_mem_read, id_mem_write, id_byte_store, id_branch;
	logic dec_uses_sr1, dec_uses_sr2;

	lc3b_word ex_result, ex_store_data, ex_target;
	lc3b_reg ex_dest, ex_load_dest;
	wb_sel_t ex_wb_sel;
	lc3b_nzp ex_nzp;
	logic ex_reg_load, ex_mem_read, ex_mem_write, ex_byte_store, ex_branch, ex_is_load;

	lc3b_word mem_result, mem_mdr, mem_target;
	lc3b_reg mem_dest;
	wb_sel_t mem_wb_sel;
	lc3b_nzp mem_nzp;
	logic mem_reg_load, mem_branch;

	lc3b_word wb_data;
	lc3b_reg wb_dest;
	logic wb_load;

	flow_control flow_ctl (
		.mem_read1, .resp_a, .mem_read2, .mem_write2, .resp_b,
		.ex_is_load, .ex_load_dest,
		.id_sr1(dec_sr1), .id_sr2(dec_sr2),
		.id_uses_sr1(dec_uses_sr1), .id_uses_sr2(dec_uses_sr2),
		.flow, .bubble
	);

	instruction_fetch if_stage (
		.clk, .reset, .flow, .bubble, .squash, .br_target, .mem_rdata1, .resp_a,
		.mem_addr1, .mem_read1, .if_ir, .if_pc
	);

	instruction_decode id_stage (
		.clk, .reset, .flow, .bubble, .squash, .if_ir, .if_pc,
		.wb_load, .wb_dest, .wb_data,
		.id_sr1_val, .id_sr2_val, .id_sr1, .id_sr2, .id_dest, .id_imm,
		.id_alu_op, .id_use_imm, .id_wb_sel, .id_reg_load, .id_mem_read,
		.id_mem_write, .id_byte_store, .id_branch, .id_nzp,
		.dec_sr1, .dec_sr2, .dec_uses_sr1, .dec_uses_sr2
	);

	// the ex/mem register is the newest forwarding source
	execution_module ex_stage (
		.clk, .reset, .flow, .squash,
		.id_sr1_val, .id_sr2_val, .id_sr1, .id_sr2, .id_dest, .id_imm,
		.id_alu_op, .id_use_imm, .id_wb_sel, .id_reg_load, .id_mem_read,
		.id_mem_write, .id_byte_store, .id_branch, .id_nzp,
		.mem_dest(ex_dest), .mem_reg_load(ex_reg_load), .mem_result(ex_result),
		.wb_dest, .wb_load, .wb_data,
		.ex_result, .ex_store_data, .ex_dest, .ex_wb_sel, .ex_reg_load, .ex_mem_read,
		.ex_mem_write, .ex_byte_store, .ex_branch, .ex_nzp, .ex_target,
		.ex_load_dest, .ex_is_load
	);

	memory_module mem_stage (
		.clk, .reset, .flow, .squash, .resp_b, .mem_rdata2,
		.ex_result, .ex_store_data, .ex_dest, .ex_wb_sel, .ex_reg_load, .ex_mem_read,
		.ex_mem_write, .ex_byte_store, .ex_branch, .ex_nzp, .ex_target,
		.mem_addr2, .mem_read2, .mem_write2, .mem_wdata2, .mem_byte_enable2,
		.mem_result, .mem_mdr, .mem_dest, .mem_wb_sel, .mem_reg_load,
		.mem_branch, .mem_nzp, .mem_target
	);

	writeback_module wb_stage (
		.clk, .reset, .flow,
		.mem_result, .mem_mdr, .mem_dest, .mem_wb_sel, .mem_reg_load,
		.mem_branch, .mem_nzp, .mem_target,
		.wb_load, .wb_dest, .wb_data, .squash, .br_target
	);

endmodule : cpu_datapath

//--- source/flow_control.sv
`timescale 1ns/1ns

module flow_control (
	input logic mem_read1,
	input logic resp_a,
	input logic mem_read2,
	input logic mem_write2,
	input logic resp_b,
	input logic ex_is_load,
	input lc3b_types::lc3b_reg ex_load_dest,
	input lc3b_types::lc3b_reg id_sr1,
	input lc3b_types::lc3b_reg id_sr2,
	input logic id_uses_sr1,
	input logic id_uses_sr2,
	output logic flow,
	output logic bubble
);

	logic fetch_wait, data_wait;
	logic hit_sr1, hit_sr2;

	// either port still waiting freezes every stage
	assign fetch_wait = mem_read1 & ~resp_a;
	assign data_wait = (mem_read2 | mem_write2) & ~resp_b;
	assign flow = ~fetch_wait & ~data_wait;

	assign hit_sr1 = id_uses_sr1 && (id_sr1 == ex_load_dest);
	assign hit_sr2 = id_uses_sr2 && (id_sr2 == ex_load_dest);
	assign bubble = ex_is_load & (hit_sr1 | hit_sr2); // load data not ready for forwarding yet

endmodule : flow_control

//--- source/instruction_fetch.sv
`timescale 1ns/1ns

module instruction_fetch (
	input logic clk,
	input logic reset,
	input logic flow,
	input logic bubble,
	input logic squash,
	input lc3b_types::lc3b_word br_target,
	input lc3b_types::lc3b_word mem_rdata1,
	input logic resp_a,
	output lc3b_types::lc3b_word mem_addr1,
	output logic mem_read1,
	output lc3b_types::lc3b_word if_ir,
	output lc3b_types::lc3b_word if_pc
);
	import lc3b_types::*;
	import lc3b_isa_pkg::*;

	lc3b_word pc, pc_next, ir_held;
	logic fetch_on, ir_done, advance;

	assign pc_next = pc + 16'd2;
	assign mem_addr1 = pc;
	assign mem_read1 = fetch_on & ~ir_done; // drop once the word is parked
	assign advance = flow & fetch_on;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
			fetch_on <= 1'b0;
			ir_done <= 1'b0;
			if_ir <= NOP_INSTR;
		end else begin
			fetch_on <= 1'b1;
			if (advance) begin
				ir_done <= 1'b0;
				if (squash) begin
					pc <= br_target;
					if_ir <= NOP_INSTR;
				end else if (!bubble) begin
					pc <= pc_next;
					if_ir <= ir_done ? ir_held : mem_rdata1;
				end
			end else if (resp_a) begin
				ir_done <= 1'b1; // data port still busy
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!flow && resp_a)
			ir_held <= mem_rdata1;
		if (advance && !squash && !bubble)
			if_pc <= pc_next;
	end

endmodule : instruction_fetch

//--- source/memory_module.sv
`timescale 1ns/1ns

module memory_module (
	input logic clk,
	input logic reset,
	input logic flow,
	input logic squash,
	input logic resp_b,
	input lc3b_types::lc3b_word mem_rdata2,
	input lc3b_types::lc3b_word ex_result,
	input lc3b_types::lc3b_word ex_store_data,
	input lc3b_types::lc3b_reg ex_dest,
	input lc3b_isa_pkg::wb_sel_t ex_wb_sel,
	input logic ex_reg_load,
	input logic ex_mem_read,
	input logic ex_mem_write,
	input logic ex_byte_store,
	input logic ex_branch,
	input lc3b_types::lc3b_nzp ex_nzp,
	input lc3b_types::lc3b_word ex_target,
	output lc3b_types::lc3b_word mem_addr2,
	output logic mem_read2,
	output logic mem_write2,
	output lc3b_types::lc3b_word mem_wdata2,
	output lc3b_types::lc3b_mem_wmask mem_byte_enable2,
	output lc3b_types::lc3b_word mem_result,
	output lc3b_types::lc3b_word mem_mdr,
	output lc3b_types::lc3b_reg mem_dest,
	output lc3b_isa_pkg::wb_sel_t mem_wb_sel,
	output logic mem_reg_load,
	output logic mem_branch,
	output lc3b_types::lc3b_nzp mem_nzp,
	output lc3b_types::lc3b_word mem_target
);
	import lc3b_types::*;

	lc3b_word rdata_held;
	logic done; // access finished, waiting on fetch

	assign mem_addr2 = ex_result;
	assign mem_wdata2 = ex_store_data;
	assign mem_read2 = ex_mem_read & ~done & ~squash;
	assign mem_write2 = ex_mem_write & ~done & ~squash; // squashed stores never issue

	always_comb begin
		if (!ex_byte_store)
			mem_byte_enable2 = 2'b11;
		else
			mem_byte_enable2 = ex_result[0] ? 2'b10 : 2'b01;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			done <= 1'b0;
			mem_reg_load <= 1'b0;
			mem_branch <= 1'b0;
		end else if (flow) begin
			done <= 1'b0;
			mem_reg_load <= ex_reg_load & ~squash;
			mem_branch <= ex_branch & ~squash;
		end else if (resp_b) begin
			done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!flow && resp_b)
			rdata_held <= mem_rdata2;
		if (flow) begin
			mem_result <= ex_result;
			mem_mdr <= done ? rdata_held : mem_rdata2;
			mem_dest <= ex_dest;
			mem_wb_sel <= ex_wb_sel;
			mem_nzp <= ex_nzp;
			mem_target <= ex_target;
		end
	end

endmodule : memory_module

//--- source/writeback_module.sv
`timescale 1ns/1ns

module writeback_module (
	input logic clk,
	input logic reset,
	input logic flow,
	input lc3b_types::lc3b_word mem_result,
	input lc3b_types::lc3b_word mem_mdr,
	input lc3b_types::lc3b_reg mem_dest,
	input lc3b_isa_pkg::wb_sel_t mem_wb_sel,
	input logic mem_reg_load,
	input logic mem_branch,
	input lc3b_types::lc3b_nzp mem_nzp,
	input lc3b_types::lc3b_word mem_target,
	output logic wb_load,
	output lc3b_types::lc3b_reg wb_dest,
	output lc3b_types::lc3b_word wb_data,
	output logic squash,
	output lc3b_types::lc3b_word br_target
);
	import lc3b_types::*;
	import lc3b_isa_pkg::*;

	lc3b_nzp cc, new_cc;

	assign wb_load = mem_reg_load;
	assign wb_dest = mem_dest;
	assign wb_data = (mem_wb_sel == wb_mem) ? mem_mdr : mem_result;

	always_comb begin
		if (wb_data[15])
			new_cc = 3'b100;
		else if (wb_data == '0)
			new_cc = 3'b010;
		else
			new_cc = 3'b001;
	end

	// cc already holds the result of the instruction just ahead
	assign squash = mem_branch & |(mem_nzp & cc);
	assign br_target = mem_target;

	always_ff @(posedge clk) begin
		if (reset)
			cc <= 3'b010;
		else if (flow && wb_load)
			cc <= new_cc;
	end

endmodule : writeback_module
